/* mbus_arbiter.sv */
// Main-bus arbiter: 68000 has priority over the Z80 window, one access in flight.
// ROM uses a toggle req/ack; rom_req keeps its value through reset.
// Unmapped reads and refused Z80-area reads return OPEN_BUS_WORD.
`default_nettype none

module mbus_arbiter (
	input  logic                   MCLK,
	input  logic                   reset,
	input  logic                   m68k_as_n,
	input  logic                   m68k_uds_n,
	input  logic                   m68k_lds_n,
	input  logic                   m68k_rnw,
	input  md_bus_pkg::m68k_addr_t m68k_addr,
	input  md_bus_pkg::word_t      m68k_wdata,
	input  md_bus_pkg::m68k_addr_t rom_sz,
	input  md_bus_pkg::word_t      rom_data,
	input  logic                   rom_ack,
	output md_bus_pkg::word_t      m68k_rdata,
	output logic                   m68k_dtack_n,
	output md_bus_pkg::m68k_addr_t rom_addr,
	output logic                   rom_req,
	output logic                   z80_busrq_n,
	output logic                   z80_reset_n,
	zbus_if.mbus                   zbus,
	z80win_if.mbus                 win,
	wram_if.mbus                   wram
);
	import md_bus_pkg::*;

	mbus_state_t mstate;
	mbus_src_t   msrc;
	m68k_addr_t  bus_addr;
	word_t       bus_wdata;
	logic        bus_rnw;
	logic        bus_uds_n;
	logic        bus_lds_n;
	word_t       bus_data;
	logic        ram_sel;
	logic        rom_hit;

	// ROM only below the Z80 area and under the loaded size
	assign rom_hit  = ({bus_addr, 1'b0} < ROM_REGION_TOP) && (bus_addr < rom_sz);
	assign rom_addr = bus_addr;

	// Z80 area gets a byte address, lane picked by the upper strobe
	assign zbus.addr    = {bus_addr[14:1], bus_uds_n};
	assign zbus.wdata   = bus_uds_n ? bus_wdata[7:0] : bus_wdata[15:8];
	assign zbus.rnw     = bus_rnw;
	assign zbus.granted = ~z80_busrq_n & z80_reset_n;

	assign wram.addr  = bus_addr[WRAM_AW:1];
	assign wram.wdata = bus_wdata;
	assign wram.we_u  = ram_sel & ~bus_rnw & ~bus_uds_n;
	assign wram.we_l  = ram_sel & ~bus_rnw & ~bus_lds_n;

	always_ff @(posedge MCLK) begin
		if (reset) begin
			mstate       <= MBUS_IDLE;
			msrc         <= SRC_M68K;
			bus_rnw      <= 1'b1;
			bus_uds_n    <= 1'b1;
			bus_lds_n    <= 1'b1;
			ram_sel      <= 1'b0;
			zbus.sel     <= 1'b0;
			m68k_dtack_n <= 1'b1;
			win.dtack_n  <= 1'b1;
			z80_busrq_n  <= 1'b1;
			z80_reset_n  <= 1'b0;
		end else begin
			// Acknowledges drop once the master releases its strobe
			if (m68k_as_n) begin
				m68k_dtack_n <= 1'b1;
			end
			if (~win.req) begin
				win.dtack_n <= 1'b1;
			end

			case (mstate)
				MBUS_IDLE: begin
					ram_sel <= 1'b0;
					if (~m68k_as_n & m68k_dtack_n) begin
						msrc      <= SRC_M68K;
						bus_addr  <= m68k_addr;
						bus_wdata <= m68k_wdata;
						bus_rnw   <= m68k_rnw;
						bus_uds_n <= m68k_uds_n;
						bus_lds_n <= m68k_lds_n;
						bus_data  <= OPEN_BUS_WORD;
						mstate    <= MBUS_SELECT;
					end else if (win.req & win.dtack_n) begin
						msrc      <= SRC_Z80;
						bus_addr  <= win.addr;
						bus_wdata <= {win.wdata, win.wdata};
						bus_rnw   <= win.rnw;
						// Odd Z80 address is the low lane
						bus_uds_n <= win.odd;
						bus_lds_n <= ~win.odd;
						bus_data  <= OPEN_BUS_WORD;
						mstate    <= MBUS_SELECT;
					end
				end

				MBUS_SELECT: begin
					mstate <= MBUS_FINISH;
					if (rom_hit) begin
						rom_req <= ~rom_ack;
						mstate  <= MBUS_ROM_READ;
					end else if (&bus_addr[23:21]) begin
						ram_sel <= 1'b1;
						mstate  <= MBUS_RAM_READ;
					end else if (bus_addr[23:16] == ZAREA_PAGE) begin
						mstate <= MBUS_ZBUS_PRE;
					end else if ({bus_addr, 1'b0} == CTRL_BUSREQ_ADDR) begin
						bus_data[CTRL_BIT] <= z80_busrq_n;
						if (~bus_rnw & ~bus_uds_n) begin
							z80_busrq_n <= ~bus_wdata[CTRL_BIT];
						end
					end else if ({bus_addr, 1'b0} == CTRL_RESET_ADDR) begin
						bus_data[CTRL_BIT] <= z80_reset_n;
						if (~bus_rnw & ~bus_uds_n) begin
							z80_reset_n <= bus_wdata[CTRL_BIT];
						end
					end
				end

				MBUS_RAM_READ: begin
					ram_sel  <= 1'b0;
					bus_data <= wram.rdata;
					mstate   <= MBUS_FINISH;
				end

				MBUS_ROM_READ: begin
					if (rom_req == rom_ack) begin
						bus_data <= rom_data;
						mstate   <= MBUS_FINISH;
					end
				end

				// 68000 byte strobes may lag the address strobe
				MBUS_ZBUS_PRE: begin
					if (msrc == SRC_Z80) begin
						zbus.sel <= 1'b1;
						mstate   <= MBUS_ZBUS_READ;
					end else if (m68k_as_n | ~m68k_uds_n | ~m68k_lds_n) begin
						bus_uds_n <= m68k_uds_n;
						bus_lds_n <= m68k_lds_n;
						zbus.sel  <= 1'b1;
						mstate    <= MBUS_ZBUS_READ;
					end
				end

				MBUS_ZBUS_READ: begin
					if (~zbus.dtack_n) begin
						zbus.sel <= 1'b0;
						bus_data <= {zbus.rdata, zbus.rdata};
						mstate   <= MBUS_FINISH;
					end
				end

				MBUS_FINISH: begin
					if (msrc == SRC_M68K) begin
						m68k_rdata   <= bus_data;
						m68k_dtack_n <= 1'b0;
					end else begin
						win.rdata   <= win.odd ? bus_data[7:0] : bus_data[15:8];
						win.dtack_n <= 1'b0;
					end
					mstate <= MBUS_IDLE;
				end

				default: mstate <= MBUS_IDLE;
			endcase
		end
	end

endmodule

`default_nettype wire

/* md_bus.f */
md_bus_pkg.sv
md_bus_if.sv
work_ram.sv
mbus_arbiter.sv
zbus_arbiter.sv
md_bus_top.sv
tb_md_bus.sv

/* md_bus_if.sv */
// Internal links between the main-bus arbiter, the Z80-bus arbiter and work RAM.
// Completion on zbus_if and z80win_if is a level dtack_n after sel or req.
`default_nettype none

// Main bus into the Z80 area
interface zbus_if;
	import md_bus_pkg::*;

	logic        sel;
	logic [14:0] addr;
	byte_t       wdata;
	logic        rnw;
	logic        granted;
	byte_t       rdata;
	logic        dtack_n;

	modport mbus (output sel, addr, wdata, rnw, granted, input rdata, dtack_n);
	modport zbus (input sel, addr, wdata, rnw, granted, output rdata, dtack_n);
endinterface

// Z80 bank window onto the main bus
interface z80win_if;
	import md_bus_pkg::*;

	logic       req;
	m68k_addr_t addr;
	logic       odd;
	byte_t      wdata;
	logic       rnw;
	byte_t      rdata;
	logic       dtack_n;

	modport z80  (output req, addr, odd, wdata, rnw, input rdata, dtack_n);
	modport mbus (input req, addr, odd, wdata, rnw, output rdata, dtack_n);
endinterface

interface wram_if;
	import md_bus_pkg::*;

	logic [WRAM_AW-1:0] addr;
	word_t              wdata;
	logic               we_u;
	logic               we_l;
	word_t              rdata;

	modport mbus (output addr, wdata, we_u, we_l, input rdata);
	modport ram  (input addr, wdata, we_u, we_l, output rdata);
endinterface

`default_nettype wire

/* md_bus_pkg.sv */
// Shared types and address map of the main bus and the Z80 bus.
// Main-bus addresses are word addresses (bits 23:1); byte constants are 24 bits wide.
`default_nettype none

package md_bus_pkg;

	// ------------------------------------------------------------------------
	// Bus types
	// ------------------------------------------------------------------------
	typedef logic [23:1] m68k_addr_t;
	typedef logic [15:0] word_t;
	typedef logic [7:0]  byte_t;
	typedef logic [15:0] z80_addr_t;
	// Main-bus address bits 23:15 for the Z80 window
	typedef logic [8:0]  bank_t;

	typedef enum logic [2:0] {
		MBUS_IDLE,
		MBUS_SELECT,
		MBUS_RAM_READ,
		MBUS_ROM_READ,
		MBUS_ZBUS_PRE,
		MBUS_ZBUS_READ,
		MBUS_FINISH
	} mbus_state_t;

	typedef enum logic {SRC_M68K, SRC_Z80} mbus_src_t;

	typedef enum logic [1:0] {ZBUS_IDLE, ZBUS_READ, ZBUS_FINISH} zbus_state_t;

	typedef enum logic {ZSRC_MBUS, ZSRC_Z80} zbus_src_t;

	// ------------------------------------------------------------------------
	// Memory sizes and address map
	// ------------------------------------------------------------------------
	localparam int WRAM_AW = 15;
	localparam int ZRAM_AW = 13;

	localparam logic [23:0] ROM_REGION_TOP   = 24'hA00000;
	localparam logic [7:0]  ZAREA_PAGE       = 8'hA0;
	localparam logic [23:0] CTRL_BUSREQ_ADDR = 24'hA11100;
	localparam logic [23:0] CTRL_RESET_ADDR  = 24'hA11200;

	// Z80 side
	localparam logic [7:0]  Z80_BANK_PAGE   = 8'h60;
	localparam z80_addr_t   Z80_WINDOW_BASE = 16'h8000;
	localparam logic [7:0]  Z80_VDP_PAGE    = 8'h7F;

	// Constant read value of unmapped space
	localparam word_t       OPEN_BUS_WORD = 16'hFFFF;
	localparam int          CTRL_BIT      = 8;

endpackage

`default_nettype wire

/* md_bus_top.sv */
// Main-bus and Z80-bus fabric with 68000 and Z80 master ports as plain pins.
// No clock enables; all logic runs every MCLK.
`default_nettype none

module md_bus_top (
	input  logic                   MCLK,
	input  logic                   reset,
	input  logic                   m68k_as_n,
	input  logic                   m68k_uds_n,
	input  logic                   m68k_lds_n,
	input  logic                   m68k_rnw,
	input  md_bus_pkg::m68k_addr_t m68k_addr,
	input  md_bus_pkg::word_t      m68k_wdata,
	input  logic                   z80_mreq_n,
	input  logic                   z80_rd_n,
	input  logic                   z80_wr_n,
	input  md_bus_pkg::z80_addr_t  z80_addr,
	input  md_bus_pkg::byte_t      z80_wdata,
	input  md_bus_pkg::m68k_addr_t rom_sz,
	input  md_bus_pkg::word_t      rom_data,
	input  logic                   rom_ack,
	output md_bus_pkg::word_t      m68k_rdata,
	output logic                   m68k_dtack_n,
	output md_bus_pkg::byte_t      z80_rdata,
	output logic                   z80_wait_n,
	output logic                   z80_busrq_n,
	output logic                   z80_reset_n,
	output md_bus_pkg::m68k_addr_t rom_addr,
	output logic                   rom_req
);

	zbus_if   zbus ();
	z80win_if win ();
	wram_if   wram ();

	mbus_arbiter i_mbus_arbiter (
		.MCLK         (MCLK),
		.reset        (reset),
		.m68k_as_n    (m68k_as_n),
		.m68k_uds_n   (m68k_uds_n),
		.m68k_lds_n   (m68k_lds_n),
		.m68k_rnw     (m68k_rnw),
		.m68k_addr    (m68k_addr),
		.m68k_wdata   (m68k_wdata),
		.rom_sz       (rom_sz),
		.rom_data     (rom_data),
		.rom_ack      (rom_ack),
		.m68k_rdata   (m68k_rdata),
		.m68k_dtack_n (m68k_dtack_n),
		.rom_addr     (rom_addr),
		.rom_req      (rom_req),
		.z80_busrq_n  (z80_busrq_n),
		.z80_reset_n  (z80_reset_n),
		.zbus         (zbus.mbus),
		.win          (win.mbus),
		.wram         (wram.mbus)
	);

	zbus_arbiter i_zbus_arbiter (
		.MCLK       (MCLK),
		.reset      (reset),
		.z80_mreq_n (z80_mreq_n),
		.z80_rd_n   (z80_rd_n),
		.z80_wr_n   (z80_wr_n),
		.z80_addr   (z80_addr),
		.z80_wdata  (z80_wdata),
		.z80_rdata  (z80_rdata),
		.z80_wait_n (z80_wait_n),
		.zbus       (zbus.zbus),
		.win        (win.z80)
	);

	work_ram i_work_ram (
		.MCLK (MCLK),
		.wram (wram.ram)
	);

endmodule

`default_nettype wire

/* run_sim.sh */
#!/usr/bin/env bash
# Builds the md_bus testbench with Verilator, runs it and checks for the pass line
cd "$(dirname "$0")" || exit 1

verilator --binary --assert --timescale 1ns/1ps --top-module tb_md_bus \
	-f md_bus.f -Mdir obj_dir -o vtb_md_bus
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

output=$(./obj_dir/vtb_md_bus)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if printf '%s\n' "$output" | grep -qF '** PASS **'; then
	exit 0
fi
exit 1

/* tb_md_bus.sv */
// Testbench for md_bus_top: one master at a time, ROM model with random ack delay.
// Memories start undefined, so only locations written earlier are read back.
`default_nettype none

module tb_md_bus;
	timeunit 1ns;
	timeprecision 1ps;
	import md_bus_pkg::*;

	// About 250 accesses of at most 20 cycles each, with a wide margin
	localparam int MAX_CYCLES   = 20000;
	localparam int ACCESS_LIMIT = 32;
	localparam logic [23:0] ROM_BYTES = 24'h200000;

	logic       MCLK;
	logic       reset;
	logic       m68k_as_n;
	logic       m68k_uds_n;
	logic       m68k_lds_n;
	logic       m68k_rnw;
	m68k_addr_t m68k_addr;
	word_t      m68k_wdata;
	logic       z80_mreq_n;
	logic       z80_rd_n;
	logic       z80_wr_n;
	z80_addr_t  z80_addr;
	byte_t      z80_wdata;
	m68k_addr_t rom_sz;
	word_t      rom_data;
	logic       rom_ack;
	word_t      m68k_rdata;
	logic       m68k_dtack_n;
	byte_t      z80_rdata;
	logic       z80_wait_n;
	logic       z80_busrq_n;
	logic       z80_reset_n;
	m68k_addr_t rom_addr;
	logic       rom_req;

	// Reference model
	word_t       wram_model [0:32767];
	byte_t       zram_model [0:8191];
	logic [8:0]  bank_model;
	logic        busrq_n_model;
	logic        zreset_n_model;
	logic [12:0] z_written [$];

	int    seed = 32'he0df;
	int    checks;
	int    errors;
	int    checks_at_start;
	int    errors_at_start;
	int    cycle_count;
	string test_name;

	md_bus_top i_md_bus_top (
		.MCLK         (MCLK),
		.reset        (reset),
		.m68k_as_n    (m68k_as_n),
		.m68k_uds_n   (m68k_uds_n),
		.m68k_lds_n   (m68k_lds_n),
		.m68k_rnw     (m68k_rnw),
		.m68k_addr    (m68k_addr),
		.m68k_wdata   (m68k_wdata),
		.z80_mreq_n   (z80_mreq_n),
		.z80_rd_n     (z80_rd_n),
		.z80_wr_n     (z80_wr_n),
		.z80_addr     (z80_addr),
		.z80_wdata    (z80_wdata),
		.rom_sz       (rom_sz),
		.rom_data     (rom_data),
		.rom_ack      (rom_ack),
		.m68k_rdata   (m68k_rdata),
		.m68k_dtack_n (m68k_dtack_n),
		.z80_rdata    (z80_rdata),
		.z80_wait_n   (z80_wait_n),
		.z80_busrq_n  (z80_busrq_n),
		.z80_reset_n  (z80_reset_n),
		.rom_addr     (rom_addr),
		.rom_req      (rom_req)
	);

	initial begin
		MCLK = 1'b0;
		forever #50 MCLK = ~MCLK;
	end

	// ROM answers a toggled request after 0 to 7 cycles
	initial begin : rom_model
		logic [31:0] rnd_delay;
		rom_ack  = 1'b0;
		rom_data = '0;
		forever begin
			@(posedge MCLK);
			#10;
			if ((rom_req ^ rom_ack) === 1'b1) begin
				rnd_delay = $random(seed);
				repeat (rnd_delay[2:0]) begin
					@(posedge MCLK);
					#10;
				end
				rom_data = rom_addr[16:1] ^ 16'hA5C3;
				rom_ack  = rom_req;
			end
		end
	end

	initial begin : watchdog
		cycle_count = 0;
		while (cycle_count < MAX_CYCLES) begin
			@(posedge MCLK);
			cycle_count++;
		end
		$display("Timeout after %0d cycles, the run did not finish", MAX_CYCLES);
		$display("** FAIL **");
		$finish;
	end

	// ------------------------------------------------------------------------
	// Checking and bus tasks
	// ------------------------------------------------------------------------
	task automatic check_value(input string what, input word_t expected, input word_t actual);
		checks++;
		assert (actual === expected) else begin
			$display("** Error %s: %s expected %h, actual %h", test_name, what, expected,
				actual);
			errors++;
		end
	endtask

	function automatic word_t ctrl_word(input logic b);
		ctrl_word = {7'h7F, b, 8'hFF};
	endfunction

	task automatic begin_test(input string name);
		test_name       = name;
		checks_at_start = checks;
		errors_at_start = errors;
	endtask

	task automatic end_test();
		$display("Test %-12s %0d checks, %0d errors", test_name, checks - checks_at_start,
			errors - errors_at_start);
	endtask

	task automatic m68k_access(input logic [23:0] addr, input logic rnw, input logic uds_n,
			input logic lds_n, input word_t wdata, output word_t rdata);
		int wait_cycles;
		wait_cycles = 0;
		m68k_addr   = addr[23:1];
		m68k_wdata  = wdata;
		m68k_rnw    = rnw;
		m68k_uds_n  = uds_n;
		m68k_lds_n  = lds_n;
		m68k_as_n   = 1'b0;
		do begin
			@(posedge MCLK);
			#10;
			wait_cycles++;
		end while (m68k_dtack_n && wait_cycles < ACCESS_LIMIT);
		assert (!m68k_dtack_n) else begin
			$display("%s: 68000 access at %h never got DTACK", test_name, addr);
			errors++;
		end
		rdata      = m68k_rdata;
		m68k_as_n  = 1'b1;
		m68k_uds_n = 1'b1;
		m68k_lds_n = 1'b1;
		m68k_rnw   = 1'b1;
		@(posedge MCLK);
		#10;
		assert (m68k_dtack_n) else begin
			$display("%s: DTACK stayed low after AS rose at %h", test_name, addr);
			errors++;
		end
	endtask

	task automatic m68k_write(input logic [23:0] addr, input logic uds_n, input logic lds_n,
			input word_t wdata);
		word_t unused;
		m68k_access(addr, 1'b0, uds_n, lds_n, wdata, unused);
	endtask

	task automatic m68k_check(input logic [23:0] addr, input logic uds_n, input logic lds_n,
			input word_t expected);
		word_t rdata;
		m68k_access(addr, 1'b1, uds_n, lds_n, 16'h0000, rdata);
		check_value($sformatf("68000 read %h", addr), expected, rdata);
	endtask

	task automatic z80_access(input z80_addr_t addr, input logic rnw, input byte_t wdata,
			output byte_t rdata);
		int wait_cycles;
		wait_cycles = 0;
		z80_addr    = addr;
		z80_wdata   = wdata;
		z80_rd_n    = ~rnw;
		z80_wr_n    = rnw;
		z80_mreq_n  = 1'b0;
		#1;
		assert (!z80_wait_n) else begin
			$display("%s: WAIT did not fall for Z80 access at %h", test_name, addr);
			errors++;
		end
		do begin
			@(posedge MCLK);
			#10;
			wait_cycles++;
		end while (!z80_wait_n && wait_cycles < ACCESS_LIMIT);
		assert (z80_wait_n) else begin
			$display("%s: WAIT never returned high for Z80 access at %h", test_name, addr);
			errors++;
		end
		rdata      = z80_rdata;
		z80_mreq_n = 1'b1;
		z80_rd_n   = 1'b1;
		z80_wr_n   = 1'b1;
		@(posedge MCLK);
		#10;
	endtask

	task automatic z80_write(input z80_addr_t addr, input byte_t wdata);
		byte_t unused;
		z80_access(addr, 1'b0, wdata, unused);
	endtask

	task automatic z80_check(input z80_addr_t addr, input byte_t expected);
		byte_t rdata;
		z80_access(addr, 1'b1, 8'h00, rdata);
		check_value($sformatf("Z80 read %h", addr), {8'h00, expected}, {8'h00, rdata});
	endtask

	// ------------------------------------------------------------------------
	// Tests
	// ------------------------------------------------------------------------
	task automatic test_reset_state();
		begin_test("reset_state");
		check_value("dtack_n", 16'h0001, {15'b0, m68k_dtack_n});
		check_value("wait_n", 16'h0001, {15'b0, z80_wait_n});
		check_value("busrq_n", 16'h0001, {15'b0, z80_busrq_n});
		check_value("reset_n", 16'h0000, {15'b0, z80_reset_n});
		m68k_check(24'hA11100, 1'b0, 1'b0, ctrl_word(busrq_n_model));
		m68k_check(24'hA11200, 1'b0, 1'b0, ctrl_word(zreset_n_model));
		end_test();
	endtask

	task automatic test_work_ram();
		logic [14:0] ram_idx [16];
		logic [31:0] rnd;
		logic [14:0] idx;
		logic [23:0] addr;
		begin_test("work_ram");
		for (int i = 0; i < 16; i++) begin
			rnd        = $random(seed);
			ram_idx[i] = rnd[14:0];
			wram_model[rnd[14:0]] = rnd[31:16];
			m68k_write({8'hE0, rnd[14:0], 1'b0}, 1'b0, 1'b0, rnd[31:16]);
		end
		// Random page from E0 to FF exercises the mirror
		for (int n = 0; n < 48; n++) begin
			rnd  = $random(seed);
			idx  = ram_idx[rnd[3:0]];
			addr = {3'b111, rnd[8:4], idx, 1'b0};
			case (rnd[10:9])
				2'd0: begin
					m68k_write(addr, 1'b0, 1'b0, rnd[31:16]);
					wram_model[idx] = rnd[31:16];
				end
				2'd1: begin
					m68k_write(addr, 1'b0, 1'b1, rnd[31:16]);
					wram_model[idx][15:8] = rnd[31:24];
				end
				2'd2: begin
					m68k_write(addr, 1'b1, 1'b0, rnd[31:16]);
					wram_model[idx][7:0] = rnd[23:16];
				end
				default: m68k_check(addr, 1'b0, 1'b0, wram_model[idx]);
			endcase
		end
		for (int i = 0; i < 16; i++) begin
			m68k_check({8'hE0, ram_idx[i], 1'b0}, 1'b0, 1'b0, wram_model[ram_idx[i]]);
		end
		end_test();
	endtask

	task automatic test_rom_unmapped();
		logic [31:0] rnd;
		logic [23:0] addr;
		begin_test("rom_unmapped");
		for (int i = 0; i < 12; i++) begin
			rnd  = $random(seed);
			addr = {3'b000, rnd[20:1], 1'b0};
			m68k_check(addr, 1'b0, 1'b0, addr[16:1] ^ 16'hA5C3);
		end
		addr = ROM_BYTES - 24'd2;
		m68k_check(addr, 1'b0, 1'b0, addr[16:1] ^ 16'hA5C3);
		m68k_check(ROM_BYTES, 1'b0, 1'b0, 16'hFFFF);
		for (int i = 0; i < 8; i++) begin
			rnd  = $random(seed);
			addr = {4'h2 + {1'b0, rnd[26:24]}, rnd[19:1], 1'b0};
			m68k_check(addr, 1'b0, 1'b0, 16'hFFFF);
		end
		m68k_check(24'hC00000, 1'b0, 1'b0, 16'hFFFF);
		m68k_check(24'hA10000, 1'b0, 1'b0, 16'hFFFF);
		m68k_check(24'hA13000, 1'b0, 1'b0, 16'hFFFF);
		end_test();
	endtask

	task automatic test_z80_area();
		logic [31:0] rnd;
		logic [12:0] z;
		begin_test("z80_area");
		// Bus not requested, Z80 in reset
		m68k_write(24'hA00010, 1'b0, 1'b1, 16'h5A5A);
		m68k_check(24'hA00010, 1'b0, 1'b1, 16'hFFFF);
		m68k_write(24'hA11100, 1'b0, 1'b1, 16'h0100);
		busrq_n_model = 1'b0;
		m68k_check(24'hA11100, 1'b0, 1'b0, ctrl_word(busrq_n_model));
		// Bus requested, Z80 still in reset
		m68k_write(24'hA00011, 1'b1, 1'b0, 16'hC3C3);
		m68k_check(24'hA00011, 1'b1, 1'b0, 16'hFFFF);
		m68k_write(24'hA11200, 1'b0, 1'b1, 16'h0100);
		zreset_n_model = 1'b1;
		m68k_check(24'hA11200, 1'b0, 1'b0, ctrl_word(zreset_n_model));
		for (int i = 0; i < 10; i++) begin
			rnd = $random(seed);
			z   = rnd[12:0];
			m68k_write({11'h500, z}, z[0], ~z[0], {rnd[23:16], rnd[23:16]});
			zram_model[z] = rnd[23:16];
			z_written.push_back(z);
		end
		// Z80 held in reset again, so this write must not reach the Z80 RAM
		m68k_write(24'hA11200, 1'b0, 1'b1, 16'h0000);
		zreset_n_model = 1'b0;
		z = z_written[0];
		m68k_write({11'h500, z}, z[0], ~z[0], {~zram_model[z], ~zram_model[z]});
		m68k_write(24'hA11200, 1'b0, 1'b1, 16'h0100);
		zreset_n_model = 1'b1;
		foreach (z_written[i]) begin
			z = z_written[i];
			m68k_check({11'h500, z}, z[0], ~z[0], {zram_model[z], zram_model[z]});
		end
		end_test();
	endtask

	task automatic test_z80_local();
		logic [31:0] rnd;
		logic [12:0] z;
		begin_test("z80_local");
		m68k_write(24'hA11100, 1'b0, 1'b1, 16'h0000);
		busrq_n_model = 1'b1;
		m68k_check(24'hA11100, 1'b0, 1'b0, ctrl_word(busrq_n_model));
		// Bus no longer requested, so this write is lost
		z = z_written[0];
		m68k_write({11'h500, z}, z[0], ~z[0], {~zram_model[z], ~zram_model[z]});
		for (int i = 0; i < 12; i++) begin
			rnd = $random(seed);
			z   = rnd[12:0];
			z80_write({2'b00, rnd[13], z}, rnd[23:16]);
			zram_model[z] = rnd[23:16];
			z_written.push_back(z);
		end
		// Read back through a random alias of the 8 KB
		foreach (z_written[i]) begin
			rnd = $random(seed);
			z   = z_written[i];
			z80_check({2'b00, rnd[0], z}, zram_model[z]);
		end
		rnd = $random(seed);
		z80_check({3'b010, rnd[12:0]}, 8'hFF);
		end_test();
	endtask

	task automatic test_bank_window();
		logic [31:0] rnd;
		logic [15:0] off [8];
		logic [23:0] baddr;
		begin_test("bank_window");
		for (int i = 0; i < 9; i++) begin
			rnd = $random(seed);
			z80_write(16'h6000, {rnd[7:1], 1'b1});
			bank_model = {1'b1, bank_model[8:1]};
		end
		for (int i = 0; i < 8; i++) begin
			rnd    = $random(seed);
			off[i] = {1'b0, rnd[14:1], 1'b0};
			baddr  = {bank_model, off[i][14:0]};
			m68k_write(baddr, 1'b0, 1'b0, rnd[31:16]);
			wram_model[baddr[15:1]] = rnd[31:16];
		end
		for (int i = 0; i < 8; i++) begin
			baddr = {bank_model, off[i][14:0]};
			z80_check(16'h8000 | off[i], wram_model[baddr[15:1]][15:8]);
			z80_check(16'h8001 | off[i], wram_model[baddr[15:1]][7:0]);
		end
		for (int i = 0; i < 8; i++) begin
			rnd   = $random(seed);
			baddr = {bank_model, off[i][14:0]};
			if (i % 2 == 0) begin
				z80_write(16'h8000 | off[i], rnd[7:0]);
				wram_model[baddr[15:1]][15:8] = rnd[7:0];
			end else begin
				z80_write(16'h8001 | off[i], rnd[7:0]);
				wram_model[baddr[15:1]][7:0] = rnd[7:0];
			end
			m68k_check(baddr, 1'b0, 1'b0, wram_model[baddr[15:1]]);
		end
		// 7Fxx lands in unmapped C000xx
		z80_check(16'h7F10, 8'hFF);
		end_test();
	endtask

	// ------------------------------------------------------------------------
	// Main sequence
	// ------------------------------------------------------------------------
	initial begin
		checks         = 0;
		errors         = 0;
		reset          = 1'b1;
		m68k_as_n      = 1'b1;
		m68k_uds_n     = 1'b1;
		m68k_lds_n     = 1'b1;
		m68k_rnw       = 1'b1;
		m68k_addr      = '0;
		m68k_wdata     = '0;
		z80_mreq_n     = 1'b1;
		z80_rd_n       = 1'b1;
		z80_wr_n       = 1'b1;
		z80_addr       = '0;
		z80_wdata      = '0;
		rom_sz         = ROM_BYTES[23:1];
		bank_model     = 9'h000;
		busrq_n_model  = 1'b1;
		zreset_n_model = 1'b0;
		repeat (8) @(posedge MCLK);
		#10;
		reset = 1'b0;

		test_reset_state();
		test_work_ram();
		test_rom_unmapped();
		test_z80_area();
		test_z80_local();
		test_bank_window();

		$display("Summary: %0d checks, %0d errors", checks, errors);
		if (errors == 0) begin
			$display("** PASS **");
		end else begin
			$display("** FAIL **");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* work_ram.sv */
// 64 KB work RAM as two byte lanes with separate write enables.
// Read data is registered, valid one cycle after the address; contents are not cleared.
`default_nettype none

module work_ram (
	input logic MCLK,
	wram_if.ram wram
);
	import md_bus_pkg::*;

	byte_t mem_u [0:2**WRAM_AW-1];
	byte_t mem_l [0:2**WRAM_AW-1];

	always_ff @(posedge MCLK) begin
		if (wram.we_u) begin
			mem_u[wram.addr] <= wram.wdata[15:8];
		end
		if (wram.we_l) begin
			mem_l[wram.addr] <= wram.wdata[7:0];
		end
		// Old data on a same-cycle write
		wram.rdata <= {mem_u[wram.addr], mem_l[wram.addr]};
	end

endmodule

`default_nettype wire

/* zbus_arbiter.sv */
// Z80-bus arbiter with 8 KB Z80 RAM and the serial bank register.
// Main-bus requests win; every access takes idle, read and finish.
`default_nettype none

module zbus_arbiter (
	input  logic                  MCLK,
	input  logic                  reset,
	input  logic                  z80_mreq_n,
	input  logic                  z80_rd_n,
	input  logic                  z80_wr_n,
	input  md_bus_pkg::z80_addr_t z80_addr,
	input  md_bus_pkg::byte_t     z80_wdata,
	output md_bus_pkg::byte_t     z80_rdata,
	output logic                  z80_wait_n,
	zbus_if.zbus                  zbus,
	z80win_if.z80                 win
);
	import md_bus_pkg::*;

	zbus_state_t zstate;
	zbus_src_t   zsrc;
	logic [14:0] zaddr;
	byte_t       zdo;
	logic        zwe;
	byte_t       zram [0:2**ZRAM_AW-1];
	byte_t       zram_q;
	byte_t       zdi;
	byte_t       z80_zbus_d;
	logic        z80_dtack_n;
	bank_t       bank;
	logic        z80_io;
	logic        z80_local;
	logic        z80_zsel;
	logic        zram_sel;
	logic        bank_sel;

	// ------------------------------------------------------------------------
	// Z80 address decode
	// ------------------------------------------------------------------------
	assign z80_io    = ~z80_mreq_n & (~z80_rd_n | ~z80_wr_n);
	assign z80_local = z80_addr[15:8] < Z80_VDP_PAGE;
	assign z80_zsel  = z80_io & z80_local;

	// 8000-FFFF through the bank, 7Fxx lands at C000xx
	assign win.req   = z80_io & ~z80_local;
	assign win.addr  = (z80_addr >= Z80_WINDOW_BASE) ? {bank, z80_addr[14:1]}
	                                                 : {16'hC000, z80_addr[7:1]};
	assign win.odd   = z80_addr[0];
	assign win.wdata = z80_wdata;
	assign win.rnw   = z80_wr_n;

	// RAM at 0000-3FFF, 8 KB mirrored
	assign zram_sel = ~zaddr[14];
	assign bank_sel = {1'b0, zaddr[14:8]} == Z80_BANK_PAGE;
	assign zdi      = zram_sel ? zram_q : OPEN_BUS_WORD[7:0];

	assign z80_wait_n = ~win.dtack_n | ~z80_dtack_n | ~z80_io;
	assign z80_rdata  = z80_dtack_n ? win.rdata : z80_zbus_d;

	always_ff @(posedge MCLK) begin
		if (zwe & zram_sel) begin
			zram[zaddr[ZRAM_AW-1:0]] <= zdo;
		end
		zram_q <= zram[zaddr[ZRAM_AW-1:0]];
	end

	// Each write to 6000-60FF shifts one bit in from the top
	always_ff @(posedge MCLK) begin
		if (reset) begin
			bank <= '0;
		end else if (bank_sel & zwe) begin
			bank <= {zdo[0], bank[8:1]};
		end
	end

	always_ff @(posedge MCLK) begin
		if (reset) begin
			zstate       <= ZBUS_IDLE;
			zsrc         <= ZSRC_MBUS;
			zwe          <= 1'b0;
			zbus.dtack_n <= 1'b1;
			z80_dtack_n  <= 1'b1;
		end else begin
			zwe <= 1'b0;
			if (~zbus.sel) begin
				zbus.dtack_n <= 1'b1;
			end
			if (~z80_zsel) begin
				z80_dtack_n <= 1'b1;
			end

			case (zstate)
				ZBUS_IDLE: begin
					if (zbus.sel & zbus.dtack_n) begin
						zaddr  <= zbus.addr;
						zdo    <= zbus.wdata;
						zwe    <= ~zbus.rnw & zbus.granted;
						zsrc   <= ZSRC_MBUS;
						zstate <= ZBUS_READ;
					end else if (z80_zsel & z80_dtack_n) begin
						zaddr  <= z80_addr[14:0];
						zdo    <= z80_wdata;
						zwe    <= ~z80_wr_n;
						zsrc   <= ZSRC_Z80;
						zstate <= ZBUS_READ;
					end
				end

				ZBUS_READ: zstate <= ZBUS_FINISH;

				ZBUS_FINISH: begin
					if (zsrc == ZSRC_MBUS) begin
						zbus.rdata   <= zbus.granted ? zdi : OPEN_BUS_WORD[7:0];
						zbus.dtack_n <= 1'b0;
					end else begin
						z80_zbus_d  <= zdi;
						z80_dtack_n <= 1'b0;
					end
					zstate <= ZBUS_IDLE;
				end

				default: zstate <= ZBUS_IDLE;
			endcase
		end
	end

endmodule

`default_nettype wire
